/* rtl/adc_clock_pkg.sv */
package adc_clock_pkg;

   // free-running clk_usb timer
   localparam int TIMER_W = 14;

   // a rising edge on this bit closes a measurement window (1024 cycles)
   localparam int WINDOW_BIT = 9;

   localparam int HEARTBEAT_BIT  = 12;  // slow blink
   localparam int FLASH_GATE_BIT = 13;  // flash pattern only updates while set
   localparam int FLASH_BIT      = 11;  // inverted into the flash pattern

   // edge counts and the change limit
   localparam int FREQ_W = 32;

   // gain accumulator width, carry not included
   localparam int PWM_W = 8;

   // LED source selector
   localparam int LED_MODE_W = 2;

   localparam logic [LED_MODE_W-1:0] LED_MODE_STATUS = 2'd0;  // heartbeat, ext clock present
   localparam logic [LED_MODE_W-1:0] LED_MODE_FLASH  = 2'd1;  // flash on both
   localparam logic [LED_MODE_W-1:0] LED_MODE_GAIN   = 2'd2;  // gain pwm, off
   localparam logic [LED_MODE_W-1:0] LED_MODE_TIMING = 2'd3;  // heartbeat, window tick

endpackage

/* rtl/adc_reg_pkg.sv */
package adc_reg_pkg;

   localparam int REG_ADDR_W = 8;
   localparam int BYTECNT_W  = 7;

   // register map
   localparam logic [REG_ADDR_W-1:0] ADDR_STATUS       = 8'h00;  // read only
   localparam logic [REG_ADDR_W-1:0] ADDR_GAIN         = 8'h01;
   localparam logic [REG_ADDR_W-1:0] ADDR_LED_CTRL     = 8'h02;
   localparam logic [REG_ADDR_W-1:0] ADDR_EXTCLK_LIMIT = 8'h03;  // 4 bytes, lsb first
   localparam logic [REG_ADDR_W-1:0] ADDR_EXTCLK_FREQ  = 8'h04;  // read only, 4 bytes

   // number of bytes behind the multi-byte addresses
   localparam int WORD_BYTES = 4;

   // reset values
   localparam logic [7:0]  GAIN_RESET     = 8'h00;
   localparam logic [7:0]  LED_CTRL_RESET = 8'h00;
   localparam logic [31:0] LIMIT_RESET    = 32'd4;

   // LED control byte, either the raw byte seen by the bus or the decoded fields
   typedef struct packed {
      logic [4:0] spare;            // unused, reads back as written
      logic       monitor_disable;  // also clears the change alarm
      logic [1:0] led_select;
   } led_ctrl_fields_t;

   typedef union packed {
      logic [7:0]       raw;
      led_ctrl_fields_t fields;
   } led_ctrl_u;

endpackage

/* rtl/adc_reg_file.sv */
`timescale 1ns/10ps

module adc_reg_file
   import adc_clock_pkg::*;
   import adc_reg_pkg::*;
(
   input  logic                  clk_usb,
   input  logic                  reset,

   // register bus
   input  logic [REG_ADDR_W-1:0] reg_address_i,
   input  logic [BYTECNT_W-1:0]  reg_bytecnt_i,
   input  logic [7:0]            reg_datai_i,
   output logic [7:0]            reg_datao_o,
   input  logic                  reg_read_i,
   input  logic                  reg_write_i,

   // status from the clock monitor
   input  logic                  extclk_change_i,
   input  logic                  ext_present_i,
   input  logic [FREQ_W-1:0]     extclk_freq_i,

   // control outputs
   output logic [7:0]            gain_o,
   output logic [LED_MODE_W-1:0] led_select_o,
   output logic                  monitor_disable_o,
   output logic [FREQ_W-1:0]     extclk_limit_o
);

   logic [7:0]        gain_q;
   led_ctrl_u         led_ctrl_q;
   logic [FREQ_W-1:0] limit_q;

   logic [1:0] byte_sel;
   logic       byte_ok;     // bytecnt inside a 4-byte register
   logic [7:0] status_byte;

   assign byte_sel = reg_bytecnt_i[1:0];
   assign byte_ok  = reg_bytecnt_i < BYTECNT_W'(WORD_BYTES);

   assign status_byte = {5'b0, led_ctrl_q.fields.monitor_disable, ext_present_i,
                         extclk_change_i};

   // write side
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q         <= GAIN_RESET;
         led_ctrl_q.raw <= LED_CTRL_RESET;
         limit_q        <= LIMIT_RESET;
      end else if (reg_write_i) begin
         case (reg_address_i)
            ADDR_GAIN:     gain_q         <= reg_datai_i;
            ADDR_LED_CTRL: led_ctrl_q.raw <= reg_datai_i;
            ADDR_EXTCLK_LIMIT: begin
               if (byte_ok)
                  limit_q[8*byte_sel +: 8] <= reg_datai_i;
            end
            default: ;  // status and freq are read only
         endcase
      end
   end

   // read side, combinational and zero when idle
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_read_i) begin
         case (reg_address_i)
            ADDR_STATUS:   reg_datao_o = status_byte;
            ADDR_GAIN:     reg_datao_o = gain_q;
            ADDR_LED_CTRL: reg_datao_o = led_ctrl_q.raw;
            ADDR_EXTCLK_LIMIT: begin
               if (byte_ok)
                  reg_datao_o = limit_q[8*byte_sel +: 8];
            end
            ADDR_EXTCLK_FREQ: begin
               if (byte_ok)
                  reg_datao_o = extclk_freq_i[8*byte_sel +: 8];
            end
            default: reg_datao_o = 8'h00;
         endcase
      end
   end

   assign gain_o            = gain_q;
   assign led_select_o      = led_ctrl_q.fields.led_select;
   assign monitor_disable_o = led_ctrl_q.fields.monitor_disable;
   assign extclk_limit_o    = limit_q;

   // the bus master never reads and writes in the same cycle
   a_no_read_write: assert property (
      @(posedge clk_usb) disable iff (reset)
      !(reg_read_i && reg_write_i)
   ) else $error("register read and write strobes high together");

endmodule

/* rtl/panel_drive.sv */
`timescale 1ns/10ps

module panel_drive
   import adc_clock_pkg::*;
(
   input  logic                  clk_usb,
   input  logic                  reset,
   input  logic [PWM_W-1:0]      gain_i,
   input  logic [LED_MODE_W-1:0] led_select_i,
   input  logic                  extclk_change_i,
   input  logic                  ext_present_i,
   output logic                  window_tick_o,
   output logic                  amp_gain_o,
   output logic                  flash_pattern_o,
   output logic                  led_armed_o,
   output logic                  led_capture_o
);

   logic [TIMER_W-1:0] timer_q;
   logic               window_bit_q;  // last value of the window bit
   logic [PWM_W:0]     pwm_acc_q;     // top bit is the carry
   logic               heartbeat;

   assign heartbeat = timer_q[HEARTBEAT_BIT];

   // timebase and window tick
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q       <= '0;
         window_bit_q  <= 1'b0;
         window_tick_o <= 1'b0;
      end else begin
         timer_q       <= timer_q + 1'b1;
         window_bit_q  <= timer_q[WINDOW_BIT];
         window_tick_o <= timer_q[WINDOW_BIT] & ~window_bit_q;  // rising edge only
      end
   end

   // flash pattern only moves in the gated half of the timer period
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_pattern_o <= 1'b0;
      else if (timer_q[FLASH_GATE_BIT])
         flash_pattern_o <= ~timer_q[FLASH_BIT];
   end

   // gain pwm, carry is high gain times per 256 cycles
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc_q <= '0;
      else
         pwm_acc_q <= {1'b0, pwm_acc_q[PWM_W-1:0]} + {1'b0, gain_i};
   end

   assign amp_gain_o = pwm_acc_q[PWM_W];

   // LED sources, the alarm overrides the selector
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         led_armed_o   <= 1'b0;
         led_capture_o <= 1'b0;
      end else if (extclk_change_i) begin
         led_armed_o   <= flash_pattern_o;
         led_capture_o <= flash_pattern_o;
      end else begin
         case (led_select_i)
            LED_MODE_STATUS: begin
               led_armed_o   <= heartbeat;
               led_capture_o <= ext_present_i;
            end
            LED_MODE_FLASH: begin
               led_armed_o   <= flash_pattern_o;
               led_capture_o <= flash_pattern_o;
            end
            LED_MODE_GAIN: begin
               led_armed_o   <= amp_gain_o;
               led_capture_o <= 1'b0;
            end
            LED_MODE_TIMING: begin
               led_armed_o   <= heartbeat;
               led_capture_o <= window_tick_o;
            end
            default: ;
         endcase
      end
   end

   // the monitor relies on one tick per window
   a_tick_single: assert property (
      @(posedge clk_usb) disable iff (reset)
      window_tick_o |=> !window_tick_o
   ) else $error("window tick high for two cycles");

endmodule

/* rtl/extclk_monitor.sv */
`timescale 1ns/10ps

module extclk_monitor
   import adc_clock_pkg::*;
(
   input  logic              clk_usb,
   input  logic              reset,
   input  logic              ext_clk_i,      // asynchronous
   input  logic              window_tick_i,
   input  logic              monitor_disable_i,
   input  logic [FREQ_W-1:0] extclk_limit_i,
   output logic [FREQ_W-1:0] extclk_freq_o,
   output logic              ext_present_o,
   output logic              extclk_change_o
);

   logic              ext_meta_q;
   logic              ext_sync_q;
   logic              ext_sync_d_q;   // for the edge detect
   logic              ext_rise;
   logic [FREQ_W-1:0] count_q;
   logic [FREQ_W-1:0] freq_diff;
   logic              over_limit;

   // two-flop synchroniser
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_meta_q   <= 1'b0;
         ext_sync_q   <= 1'b0;
         ext_sync_d_q <= 1'b0;
      end else begin
         ext_meta_q   <= ext_clk_i;
         ext_sync_q   <= ext_meta_q;
         ext_sync_d_q <= ext_sync_q;
      end
   end

   assign ext_rise = ext_sync_q & ~ext_sync_d_q;

   // absolute difference between last window and the one just closing
   assign freq_diff  = (extclk_freq_o > count_q) ? extclk_freq_o - count_q
                                                 : count_q - extclk_freq_o;
   assign over_limit = freq_diff > extclk_limit_i;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count_q       <= '0;
         extclk_freq_o <= '0;
      end else if (window_tick_i) begin
         extclk_freq_o <= count_q;
         count_q       <= ext_rise ? FREQ_W'(1) : '0;  // edge on the tick opens the next window
      end else if (ext_rise) begin
         count_q <= count_q + 1'b1;
      end
   end

   // sticky alarm, cleared and held off by monitor_disable
   always_ff @(posedge clk_usb) begin
      if (reset)
         extclk_change_o <= 1'b0;
      else if (monitor_disable_i)
         extclk_change_o <= 1'b0;
      else if (window_tick_i && extclk_freq_o != '0 && over_limit)
         extclk_change_o <= 1'b1;
   end

   assign ext_present_o = extclk_freq_o != '0;

   // only software or reset may clear the alarm
   a_change_sticky: assert property (
      @(posedge clk_usb)
      $fell(extclk_change_o) |-> $past(monitor_disable_i || reset)
   ) else $error("clock change alarm cleared without monitor_disable");

endmodule

/* rtl/openadc_interface.sv */
`timescale 1ns/10ps

module openadc_interface
   import adc_clock_pkg::*;
   import adc_reg_pkg::*;
(
   input  logic                  clk_usb,
   input  logic                  reset,
   input  logic                  ext_clk_i,
   input  logic [REG_ADDR_W-1:0] reg_address_i,
   input  logic [BYTECNT_W-1:0]  reg_bytecnt_i,
   input  logic [7:0]            reg_datai_i,
   input  logic                  reg_read_i,
   input  logic                  reg_write_i,
   output logic [7:0]            reg_datao_o,
   output logic                  amp_gain_o,
   output logic                  led_armed_o,
   output logic                  led_capture_o,
   output logic                  flash_pattern_o,
   output logic                  extclk_change_o
);

   logic [PWM_W-1:0]      gain;
   logic [LED_MODE_W-1:0] led_select;
   logic                  monitor_disable;
   logic [FREQ_W-1:0]     extclk_limit;
   logic [FREQ_W-1:0]     extclk_freq;
   logic                  ext_present;
   logic                  window_tick;

   adc_reg_file u_reg_file (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .reg_address_i     (reg_address_i),
      .reg_bytecnt_i     (reg_bytecnt_i),
      .reg_datai_i       (reg_datai_i),
      .reg_datao_o       (reg_datao_o),
      .reg_read_i        (reg_read_i),
      .reg_write_i       (reg_write_i),
      .extclk_change_i   (extclk_change_o),
      .ext_present_i     (ext_present),
      .extclk_freq_i     (extclk_freq),
      .gain_o            (gain),
      .led_select_o      (led_select),
      .monitor_disable_o (monitor_disable),
      .extclk_limit_o    (extclk_limit)
   );

   panel_drive u_panel (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .gain_i          (gain),
      .led_select_i    (led_select),
      .extclk_change_i (extclk_change_o),
      .ext_present_i   (ext_present),
      .window_tick_o   (window_tick),
      .amp_gain_o      (amp_gain_o),
      .flash_pattern_o (flash_pattern_o),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o)
   );

   extclk_monitor u_extclk (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .ext_clk_i         (ext_clk_i),
      .window_tick_i     (window_tick),
      .monitor_disable_i (monitor_disable),
      .extclk_limit_i    (extclk_limit),
      .extclk_freq_o     (extclk_freq),
      .ext_present_o     (ext_present),
      .extclk_change_o   (extclk_change_o)
   );

endmodule

/* sim/openadc_checker.sv */
`timescale 1ns/10ps

module openadc_checker (
   input  logic         clk_usb,
   input  logic         reset,
   // watched DUT ports
   input  logic         reg_read_i,
   input  logic [6:0]   reg_bytecnt_i,
   input  logic [7:0]   reg_datao_i,
   input  logic         amp_gain_i,
   input  logic         led_armed_i,
   input  logic         led_capture_i,
   input  logic         flash_pattern_i,
   input  logic         extclk_change_i,
   // requests from the test sequence
   input  logic         check_i,
   input  logic [2:0]   check_kind_i,
   input  logic [191:0] check_name_i,
   input  logic [31:0]  expected_i,
   input  logic [31:0]  tolerance_i,
   input  logic         count_en_i,
   output int           pass_count_o,
   output int           fail_count_o
);

   logic [31:0] read_word;     // bytes seen since the last check
   logic [31:0] amp_cnt;
   logic [31:0] armed_cnt;
   logic [31:0] capture_cnt;
   logic [31:0] led_miss_cnt;  // cycles where an LED differs from the flash pattern
   logic        count_en_q;
   logic        flash_q;       // LEDs are registered, so compare with last cycle's pattern
   logic [31:0] actual;
   logic [31:0] diff;

   always_comb begin
      case (check_kind_i)
         3'd0:    actual = read_word;
         3'd1:    actual = amp_cnt;
         3'd2:    actual = armed_cnt;
         3'd3:    actual = capture_cnt;
         3'd4:    actual = {19'b0, reg_datao_i, amp_gain_i, led_armed_i, led_capture_i,
                            flash_pattern_i, extclk_change_i};
         3'd5:    actual = led_miss_cnt;
         3'd6:    actual = {31'b0, extclk_change_i};
         default: actual = '0;
      endcase
   end

   assign diff = (actual > expected_i) ? actual - expected_i : expected_i - actual;

   // counts over the window opened by count_en_i, restarted when it opens
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count_en_q   <= 1'b0;
         flash_q      <= 1'b0;
         amp_cnt      <= '0;
         armed_cnt    <= '0;
         capture_cnt  <= '0;
         led_miss_cnt <= '0;
      end else begin
         count_en_q <= count_en_i;
         flash_q    <= flash_pattern_i;
         if (count_en_i) begin
            amp_cnt     <= (count_en_q ? amp_cnt : '0) + 32'(amp_gain_i);
            armed_cnt   <= (count_en_q ? armed_cnt : '0) + 32'(led_armed_i);
            capture_cnt <= (count_en_q ? capture_cnt : '0) + 32'(led_capture_i);
            led_miss_cnt <= (count_en_q ? led_miss_cnt : '0)
                            + 32'(led_armed_i != flash_q || led_capture_i != flash_q);
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         read_word    <= '0;
         pass_count_o <= 0;
         fail_count_o <= 0;
      end else if (check_i) begin
         if (diff <= tolerance_i) begin
            pass_count_o <= pass_count_o + 1;
            $display("PASS  %0s: 0x%0h", check_name_i, actual);
         end else begin
            fail_count_o <= fail_count_o + 1;
            $display("ERROR %0s: expected 0x%0h, actual 0x%0h (tolerance %0d)",
                     check_name_i, expected_i, actual, tolerance_i);
         end
         read_word <= '0;  // next read starts a fresh word
      end else if (reg_read_i && reg_bytecnt_i < 7'd4) begin
         read_word[8*reg_bytecnt_i[1:0] +: 8] <= reg_datao_i;
      end
   end

endmodule

/* sim/tb_openadc.sv */
`timescale 1ns/10ps

module tb_openadc
   import adc_clock_pkg::*;
   import adc_reg_pkg::*;
();

   localparam int WINDOW_CYCLES = 2 ** (WINDOW_BIT + 1);

   // what the checker compares
   localparam logic [2:0] CHK_READ      = 3'd0;  // bytes of the last register read
   localparam logic [2:0] CHK_AMP       = 3'd1;
   localparam logic [2:0] CHK_ARMED     = 3'd2;
   localparam logic [2:0] CHK_CAPTURE   = 3'd3;
   localparam logic [2:0] CHK_OUTPUTS   = 3'd4;  // all outputs packed together
   localparam logic [2:0] CHK_LED_FLASH = 3'd5;
   localparam logic [2:0] CHK_CHANGE    = 3'd6;

   logic                  clk_usb;
   logic                  reset;
   logic                  ext_clk;
   logic [REG_ADDR_W-1:0] reg_address;
   logic [BYTECNT_W-1:0]  reg_bytecnt;
   logic [7:0]            reg_datai;
   logic                  reg_read;
   logic                  reg_write;
   logic [7:0]            reg_datao;
   logic                  amp_gain;
   logic                  led_armed;
   logic                  led_capture;
   logic                  flash_pattern;
   logic                  extclk_change;

   logic         check_strobe;
   logic [2:0]   check_kind;
   logic [191:0] check_name;
   logic [31:0]  check_expected;
   logic [31:0]  check_tolerance;
   logic         count_en;
   int           pass_count;
   int           fail_count;

   int          ext_half_ns;  // 0 keeps the external clock still
   int          i;
   logic [7:0]  gain_val;
   logic [7:0]  led_val;
   logic [31:0] limit_val;
   logic [7:0]  rd;
   logic        present;

   always #5 clk_usb = ~clk_usb;

   always begin
      if (ext_half_ns == 0) begin
         ext_clk = 1'b0;
         #10;
      end else begin
         #(ext_half_ns);
         ext_clk = ~ext_clk;
      end
   end

   openadc_interface uut (
      .clk_usb(clk_usb), .reset(reset), .ext_clk_i(ext_clk),
      .reg_address_i(reg_address), .reg_bytecnt_i(reg_bytecnt), .reg_datai_i(reg_datai),
      .reg_read_i(reg_read), .reg_write_i(reg_write), .reg_datao_o(reg_datao),
      .amp_gain_o(amp_gain), .led_armed_o(led_armed), .led_capture_o(led_capture),
      .flash_pattern_o(flash_pattern), .extclk_change_o(extclk_change)
   );

   openadc_checker chk (
      .clk_usb(clk_usb), .reset(reset), .reg_read_i(reg_read), .reg_bytecnt_i(reg_bytecnt),
      .reg_datao_i(reg_datao), .amp_gain_i(amp_gain), .led_armed_i(led_armed),
      .led_capture_i(led_capture), .flash_pattern_i(flash_pattern),
      .extclk_change_i(extclk_change), .check_i(check_strobe), .check_kind_i(check_kind),
      .check_name_i(check_name), .expected_i(check_expected), .tolerance_i(check_tolerance),
      .count_en_i(count_en), .pass_count_o(pass_count), .fail_count_o(fail_count)
   );

   // edges counted in one window for a given external period
   function automatic logic [31:0] expected_freq(input int period_ns);
      return 32'(10240 / period_ns);
   endfunction

   function automatic logic [31:0] expected_status(input logic change, input logic present_bit,
                                                   input logic mon_off);
      return {29'b0, mon_off, present_bit, change};
   endfunction

   task automatic next_cycle();
      @(posedge clk_usb);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic write_reg(input logic [7:0] addr, input int cnt, input logic [7:0] data);
      reg_address = addr;
      reg_bytecnt = BYTECNT_W'(cnt);
      reg_datai   = data;
      reg_write   = 1'b1;
      next_cycle();
      reg_write   = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input int cnt, output logic [7:0] data);
      reg_address = addr;
      reg_bytecnt = BYTECNT_W'(cnt);
      reg_read    = 1'b1;
      @(posedge clk_usb);
      data = reg_datao;  // combinational, settled since the last edge
      #1;
      reg_read = 1'b0;
   endtask

   task automatic read_word(input logic [7:0] addr, input int nbytes);
      logic [7:0] data;
      for (int b = 0; b < nbytes; b++)
         read_reg(addr, b, data);
   endtask

   task automatic write_limit(input logic [31:0] value);
      for (int b = 0; b < 4; b++)
         write_reg(ADDR_EXTCLK_LIMIT, b, value[8*b +: 8]);
   endtask

   task automatic run_check(input logic [191:0] name, input logic [2:0] kind,
                            input logic [31:0] expected, input logic [31:0] tol);
      check_name      = name;
      check_kind      = kind;
      check_expected  = expected;
      check_tolerance = tol;
      check_strobe    = 1'b1;
      next_cycle();
      check_strobe    = 1'b0;
   endtask

   task automatic count_window(input int n);
      count_en = 1'b1;
      idle_cycles(n);
      count_en = 1'b0;
   endtask

   task automatic fail_timeout(input logic [383:0] what);
      $display("timeout: %0s did not happen in time", what);
      $display("Result: FAILED");
      $finish;
   endtask

   initial begin
      void'($urandom(12516));
      clk_usb = 1'b0;
      reset = 1'b1;
      ext_clk = 1'b0;
      ext_half_ns = 0;
      reg_address = '0;
      reg_bytecnt = '0;
      reg_datai = '0;
      reg_read = 1'b0;
      reg_write = 1'b0;
      check_strobe = 1'b0;
      check_kind = '0;
      check_name = '0;
      count_en = 1'b0;
      check_expected = '0;
      check_tolerance = '0;
      repeat (16) @(posedge clk_usb);
      #1 reset = 1'b0;
      next_cycle();

      read_word(ADDR_STATUS, 1);
      run_check("reset status", CHK_READ, 32'd0, 0);
      read_word(ADDR_EXTCLK_FREQ, 4);
      run_check("reset extclk freq", CHK_READ, 32'd0, 0);
      read_word(ADDR_EXTCLK_LIMIT, 4);
      run_check("reset limit", CHK_READ, 32'd4, 0);
      run_check("reset outputs", CHK_OUTPUTS, 32'd0, 0);

      gain_val = 8'($urandom);
      write_reg(ADDR_GAIN, 0, gain_val);
      read_word(ADDR_GAIN, 1);
      run_check("gain readback", CHK_READ, 32'(gain_val), 0);
      led_val = 8'($urandom);
      write_reg(ADDR_LED_CTRL, 0, led_val);
      read_word(ADDR_LED_CTRL, 1);
      run_check("led ctrl readback", CHK_READ, 32'(led_val), 0);
      limit_val = $urandom;
      write_limit(limit_val);
      read_word(ADDR_EXTCLK_LIMIT, 4);
      run_check("limit readback", CHK_READ, limit_val, 0);
      write_reg(ADDR_STATUS, 0, 8'hff);  // read only
      read_word(ADDR_STATUS, 1);
      run_check("status write ignored", CHK_READ, expected_status(0, 0, led_val[2]), 0);

      write_reg(ADDR_LED_CTRL, 0, 8'h04);  // monitor off while the clock starts
      ext_half_ns = 20;
      present = 1'b0;
      for (i = 0; i < 4000 && !present; i++) begin
         read_reg(ADDR_STATUS, 0, rd);
         present = rd[1];
      end
      if (!present)
         fail_timeout("ext_present after starting the 40 ns clock");
      idle_cycles(WINDOW_CYCLES + 8);
      read_word(ADDR_EXTCLK_FREQ, 4);
      run_check("freq at 40 ns", CHK_READ, expected_freq(40), 1);
      read_word(ADDR_STATUS, 1);
      run_check("status clock present", CHK_READ, expected_status(0, 1, 1), 0);

      gain_val = 8'($urandom);
      write_reg(ADDR_GAIN, 0, gain_val);
      write_reg(ADDR_LED_CTRL, 0, 8'h06);  // gain on the LEDs
      idle_cycles(4);
      count_window(256);
      run_check("pwm amp_gain", CHK_AMP, 32'(gain_val), 0);
      run_check("pwm led_armed", CHK_ARMED, 32'(gain_val), 0);
      run_check("pwm led_capture", CHK_CAPTURE, 32'd0, 0);

      write_limit(32'd4);
      write_reg(ADDR_LED_CTRL, 0, 8'h02);  // monitor on
      idle_cycles(2 * WINDOW_CYCLES);
      run_check("alarm idle before change", CHK_CHANGE, 32'd0, 0);
      ext_half_ns = 10;
      for (i = 0; i < 3 * WINDOW_CYCLES && !extclk_change; i++)
         next_cycle();
      if (!extclk_change)
         fail_timeout("extclk_change after the period step");
      read_word(ADDR_STATUS, 1);
      run_check("status alarm set", CHK_READ, expected_status(1, 1, 0), 0);
      run_check("alarm output set", CHK_CHANGE, 32'd1, 0);
      count_window(64);
      run_check("leds follow flash", CHK_LED_FLASH, 32'd0, 0);
      write_reg(ADDR_LED_CTRL, 0, 8'h06);
      next_cycle();
      run_check("alarm cleared", CHK_CHANGE, 32'd0, 0);
      idle_cycles(2 * WINDOW_CYCLES);
      run_check("alarm stays clear", CHK_CHANGE, 32'd0, 0);
      read_word(ADDR_EXTCLK_FREQ, 4);
      run_check("freq at 20 ns", CHK_READ, expected_freq(20), 1);

      $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* openadc_interface.f */
rtl/adc_clock_pkg.sv
rtl/adc_reg_pkg.sv
rtl/adc_reg_file.sv
rtl/panel_drive.sv
rtl/extclk_monitor.sv
rtl/openadc_interface.sv
sim/openadc_checker.sv
sim/tb_openadc.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_openadc
FILELIST  = openadc_interface.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
